/* rtl/ofdm_signal_pkg.sv */
`default_nettype none

package ofdm_signal_pkg;

    // byte stream from the demodulator
    localparam int BYTE_W       = 8;
    localparam int SIGNAL_BYTES = 3;
    localparam int SIGNAL_W     = SIGNAL_BYTES * BYTE_W;

    // legacy length and running byte count
    localparam int LEN_W   = 12;
    localparam int COUNT_W = 16;

    //////////////////////////////
    // SIGNAL field layout
    //////////////////////////////

    localparam int RATE_W     = 4;
    localparam int RATE_LSB   = 0;
    localparam int RSVD_POS   = 4;
    localparam int LEN_LSB    = 5;
    localparam int PARITY_POS = 17;
    localparam int TAIL_W     = 6;
    localparam int TAIL_LSB   = 18;

    // legacy rate codes, top bit clear means not a valid OFDM rate
    typedef enum logic [RATE_W-1:0] {
        RATE_6M  = 4'b1011,
        RATE_9M  = 4'b1111,
        RATE_12M = 4'b1010,
        RATE_18M = 4'b1110,
        RATE_24M = 4'b1001,
        RATE_36M = 4'b1101,
        RATE_48M = 4'b1000,
        RATE_54M = 4'b1100
    } legacy_rate_e;

endpackage

`default_nettype wire

/* rtl/rx_status_pkg.sv */
`default_nettype none

package rx_status_pkg;

    // packet result reported with the header and FCS strobes
    typedef enum logic [2:0] {
        E_OK               = 3'd0,
        E_PARITY_FAIL      = 3'd1,
        E_WRONG_RSVD       = 3'd2,
        E_WRONG_TAIL       = 3'd3,
        E_UNSUPPORTED_RATE = 3'd4,
        E_WRONG_FCS        = 3'd5
    } status_code_e;

    // receive controller FSM
    typedef enum logic [2:0] {
        S_IDLE         = 3'd0,
        S_SIGNAL       = 3'd1,
        S_HEADER_ERROR = 3'd2,
        S_DECODE_DATA  = 3'd3,
        S_FCS_CHECK    = 3'd4
    } rx_state_e;

    //////////////////////////////
    // FCS, reflected CRC-32
    //////////////////////////////

    localparam int          CRC_W                = 32;
    localparam logic [31:0] CRC32_POLY_REFLECTED = 32'hEDB88320;
    localparam logic [31:0] CRC32_INIT           = 32'hFFFFFFFF;
    // register value once the FCS bytes themselves went through
    localparam logic [31:0] CRC32_RESIDUE        = 32'hDEBB20E3;

endpackage

`default_nettype wire

/* rtl/signal_field_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module signal_field_decoder (
    input  wire logic                                 clock,
    input  wire logic                                 equalizer_reset,
    input  wire logic                                 collect_i,
    input  wire logic [ofdm_signal_pkg::BYTE_W-1:0]   byte_i,
    input  wire logic                                 byte_strobe_i,
    output logic                                      signal_valid_o,
    output ofdm_signal_pkg::legacy_rate_e             rate_o,
    output logic [ofdm_signal_pkg::LEN_W-1:0]         len_o,
    output rx_status_pkg::status_code_e               sig_status_o
);

    import ofdm_signal_pkg::*;
    import rx_status_pkg::*;

    logic [1:0]          byte_cnt;
    logic [SIGNAL_W-1:0] sig_sr;
    logic [SIGNAL_W-1:0] sig_word;
    logic                last_byte;
    status_code_e        sig_class;

    // first byte received ends up in the low bits
    assign sig_word  = {byte_i, sig_sr[SIGNAL_W-1:BYTE_W]};
    assign last_byte = collect_i && byte_strobe_i && (byte_cnt == 2'(SIGNAL_BYTES - 1));

    //////////////////////////////
    // byte collection
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (equalizer_reset) begin
            byte_cnt <= '0;
        end else if (!collect_i) begin
            byte_cnt <= '0;
        end else if (byte_strobe_i) begin
            if (last_byte) begin
                byte_cnt <= '0;
            end else begin
                byte_cnt <= byte_cnt + 2'd1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (collect_i && byte_strobe_i) begin
            sig_sr <= sig_word;
        end
    end

    //////////////////////////////
    // header classification
    //////////////////////////////

    // checked in this order, first failure wins
    always_comb begin
        if (^sig_word[PARITY_POS:0]) begin
            sig_class = E_PARITY_FAIL;
        end else if (sig_word[RSVD_POS]) begin
            sig_class = E_WRONG_RSVD;
        end else if (|sig_word[TAIL_LSB +: TAIL_W]) begin
            sig_class = E_WRONG_TAIL;
        end else if (!sig_word[RATE_LSB + RATE_W - 1]) begin
            sig_class = E_UNSUPPORTED_RATE;
        end else begin
            sig_class = E_OK;
        end
    end

    always_ff @(posedge clock) begin
        if (equalizer_reset) begin
            signal_valid_o <= 1'b0;
        end else begin
            signal_valid_o <= last_byte;
        end
    end

    // fields held until the next SIGNAL field
    always_ff @(posedge clock) begin
        if (last_byte) begin
            rate_o       <= legacy_rate_e'(sig_word[RATE_LSB +: RATE_W]);
            len_o        <= sig_word[LEN_LSB +: LEN_W];
            sig_status_o <= sig_class;
        end
    end

    cnt_in_range_a: assert property (@(posedge clock) disable iff (equalizer_reset)
        byte_cnt <= 2'(SIGNAL_BYTES - 1));

endmodule

`default_nettype wire

/* rtl/fcs_crc32.sv */
`timescale 1ns/1ps
`default_nettype none

module fcs_crc32 (
    input  wire logic                                 clock,
    input  wire logic                                 equalizer_reset,
    input  wire logic                                 crc_clear_i,
    input  wire logic                                 crc_en_i,
    input  wire logic [ofdm_signal_pkg::BYTE_W-1:0]   byte_i,
    output logic [rx_status_pkg::CRC_W-1:0]           crc_o
);

    import ofdm_signal_pkg::*;
    import rx_status_pkg::*;

    // one reflected shift step per bit, LSB is first on air
    function automatic logic [CRC_W-1:0] crc_fold_byte(
        input logic [CRC_W-1:0]  crc_in,
        input logic [BYTE_W-1:0] data
    );
        logic [CRC_W-1:0] c;
        logic             fb;
        c = crc_in;
        for (int i = 0; i < BYTE_W; i++) begin
            fb = c[0] ^ data[i];
            c  = c >> 1;
            if (fb) begin
                c = c ^ CRC32_POLY_REFLECTED;
            end
        end
        return c;
    endfunction

    logic [CRC_W-1:0] crc_next;

    assign crc_next = crc_fold_byte(crc_o, byte_i);

    always_ff @(posedge clock) begin
        if (equalizer_reset) begin
            crc_o <= CRC32_INIT;
        end else if (crc_clear_i) begin
            crc_o <= CRC32_INIT;
        end else if (crc_en_i) begin
            crc_o <= crc_next;
        end
    end

    // clear comes with header accept, data only after it
    clear_en_excl_a: assert property (@(posedge clock) disable iff (equalizer_reset)
        !(crc_clear_i && crc_en_i));

endmodule

`default_nettype wire

/* rtl/rx_packet_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module rx_packet_ctrl (
    input  wire logic                                  clock,
    input  wire logic                                  equalizer_reset,
    input  wire logic                                  demod_start_i,
    input  wire logic [ofdm_signal_pkg::BYTE_W-1:0]    byte_i,
    input  wire logic                                  byte_strobe_i,
    input  wire logic                                  signal_valid_i,
    input  ofdm_signal_pkg::legacy_rate_e              rate_i,
    input  wire logic [ofdm_signal_pkg::LEN_W-1:0]     len_i,
    input  rx_status_pkg::status_code_e                sig_status_i,
    input  wire logic [rx_status_pkg::CRC_W-1:0]       crc_i,
    output logic                                       collect_o,
    output logic                                       crc_clear_o,
    output logic                                       crc_en_o,
    output logic                                       demod_is_ongoing_o,
    output logic                                       pkt_header_valid_o,
    output logic                                       pkt_header_valid_strobe_o,
    output ofdm_signal_pkg::legacy_rate_e              pkt_rate_o,
    output logic [ofdm_signal_pkg::LEN_W-1:0]          pkt_len_o,
    output logic [ofdm_signal_pkg::BYTE_W-1:0]         byte_o,
    output logic                                       byte_strobe_o,
    output logic [ofdm_signal_pkg::COUNT_W-1:0]        byte_count_o,
    output logic                                       fcs_out_strobe_o,
    output logic                                       fcs_ok_o,
    output rx_status_pkg::status_code_e                status_code_o
);

    import ofdm_signal_pkg::*;
    import rx_status_pkg::*;

    rx_state_e          state;
    logic               header_good;
    logic               data_byte;
    logic [COUNT_W-1:0] count_next;
    logic               last_data_byte;
    logic               fcs_match;

    assign header_good    = (state == S_SIGNAL) && signal_valid_i && (sig_status_i == E_OK);
    assign data_byte      = (state == S_DECODE_DATA) && byte_strobe_i;
    assign count_next     = byte_count_o + 1'b1;
    assign last_data_byte = (count_next == {{(COUNT_W - LEN_W){1'b0}}, pkt_len_o});
    assign fcs_match      = (crc_i == CRC32_RESIDUE);

    // controls towards the decoder and the FCS engine
    assign collect_o   = (state == S_SIGNAL);
    assign crc_clear_o = header_good;
    assign crc_en_o    = data_byte;

    //////////////////////////////
    // packet FSM
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (equalizer_reset) begin
            state                     <= S_IDLE;
            demod_is_ongoing_o        <= 1'b0;
            pkt_header_valid_o        <= 1'b0;
            pkt_header_valid_strobe_o <= 1'b0;
            byte_strobe_o             <= 1'b0;
            byte_count_o              <= '0;
            fcs_out_strobe_o          <= 1'b0;
            fcs_ok_o                  <= 1'b0;
            status_code_o             <= E_OK;
        end else begin
            // strobes are single cycle
            pkt_header_valid_strobe_o <= 1'b0;
            byte_strobe_o             <= 1'b0;
            fcs_out_strobe_o          <= 1'b0;
            fcs_ok_o                  <= 1'b0;

            case (state)
                S_IDLE: begin
                    if (demod_start_i) begin
                        demod_is_ongoing_o <= 1'b1;
                        byte_count_o       <= '0;
                        state              <= S_SIGNAL;
                    end
                end

                S_SIGNAL: begin
                    if (signal_valid_i) begin
                        pkt_header_valid_strobe_o <= 1'b1;
                        status_code_o             <= sig_status_i;
                        if (sig_status_i == E_OK) begin
                            pkt_header_valid_o <= 1'b1;
                            // empty PSDU has no FCS to check
                            if (len_i == '0) begin
                                state <= S_FCS_CHECK;
                            end else begin
                                state <= S_DECODE_DATA;
                            end
                        end else begin
                            state <= S_HEADER_ERROR;
                        end
                    end
                end

                S_HEADER_ERROR: begin
                    demod_is_ongoing_o <= 1'b0;
                    state              <= S_IDLE;
                end

                S_DECODE_DATA: begin
                    if (byte_strobe_i) begin
                        byte_strobe_o <= 1'b1;
                        byte_count_o  <= count_next;
                        if (last_data_byte) begin
                            state <= S_FCS_CHECK;
                        end
                    end
                end

                S_FCS_CHECK: begin
                    // crc_i already holds the last byte here
                    fcs_out_strobe_o   <= 1'b1;
                    fcs_ok_o           <= fcs_match;
                    status_code_o      <= fcs_match ? E_OK : E_WRONG_FCS;
                    pkt_header_valid_o <= 1'b0;
                    demod_is_ongoing_o <= 1'b0;
                    state              <= S_IDLE;
                end

                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // header fields kept for the whole packet
    always_ff @(posedge clock) begin
        if ((state == S_SIGNAL) && signal_valid_i) begin
            pkt_rate_o <= rate_i;
            pkt_len_o  <= len_i;
        end
    end

    always_ff @(posedge clock) begin
        if (data_byte) begin
            byte_o <= byte_i;
        end
    end

    strobes_excl_a: assert property (@(posedge clock) disable iff (equalizer_reset)
        !(pkt_header_valid_strobe_o && fcs_out_strobe_o));

    fcs_ok_with_strobe_a: assert property (@(posedge clock) disable iff (equalizer_reset)
        fcs_ok_o |-> fcs_out_strobe_o);

endmodule

`default_nettype wire

/* rtl/dot11_rx_top.sv */
`timescale 1ns/1ps
`default_nettype none

module dot11_rx_top (
    input  wire logic                                  clock,
    input  wire logic                                  equalizer_reset,
    input  wire logic                                  demod_start_i,
    input  wire logic [ofdm_signal_pkg::BYTE_W-1:0]    byte_i,
    input  wire logic                                  byte_strobe_i,
    output logic                                       demod_is_ongoing_o,
    output logic                                       pkt_header_valid_o,
    output logic                                       pkt_header_valid_strobe_o,
    output ofdm_signal_pkg::legacy_rate_e              pkt_rate_o,
    output logic [ofdm_signal_pkg::LEN_W-1:0]          pkt_len_o,
    output logic [ofdm_signal_pkg::BYTE_W-1:0]         byte_o,
    output logic                                       byte_strobe_o,
    output logic [ofdm_signal_pkg::COUNT_W-1:0]        byte_count_o,
    output logic                                       fcs_out_strobe_o,
    output logic                                       fcs_ok_o,
    output rx_status_pkg::status_code_e                status_code_o
);

    import ofdm_signal_pkg::*;
    import rx_status_pkg::*;

    logic             collect;
    logic             crc_clear;
    logic             crc_en;
    logic             signal_valid;
    legacy_rate_e     sig_rate;
    logic [LEN_W-1:0] sig_len;
    status_code_e     sig_status;
    logic [CRC_W-1:0] crc;

    //////////////////////////////
    // decode stage
    //////////////////////////////

    signal_field_decoder u_signal_field_decoder (
        .clock           (clock),
        .equalizer_reset (equalizer_reset),
        .collect_i       (collect),
        .byte_i          (byte_i),
        .byte_strobe_i   (byte_strobe_i),
        .signal_valid_o  (signal_valid),
        .rate_o          (sig_rate),
        .len_o           (sig_len),
        .sig_status_o    (sig_status)
    );

    //////////////////////////////
    // execute stage
    //////////////////////////////

    fcs_crc32 u_fcs_crc32 (
        .clock           (clock),
        .equalizer_reset (equalizer_reset),
        .crc_clear_i     (crc_clear),
        .crc_en_i        (crc_en),
        .byte_i          (byte_i),
        .crc_o           (crc)
    );

    //////////////////////////////
    // result stage
    //////////////////////////////

    // first data byte is expected at least one idle cycle after the last SIGNAL byte
    rx_packet_ctrl u_rx_packet_ctrl (
        .clock                     (clock),
        .equalizer_reset           (equalizer_reset),
        .demod_start_i             (demod_start_i),
        .byte_i                    (byte_i),
        .byte_strobe_i             (byte_strobe_i),
        .signal_valid_i            (signal_valid),
        .rate_i                    (sig_rate),
        .len_i                     (sig_len),
        .sig_status_i              (sig_status),
        .crc_i                     (crc),
        .collect_o                 (collect),
        .crc_clear_o               (crc_clear),
        .crc_en_o                  (crc_en),
        .demod_is_ongoing_o        (demod_is_ongoing_o),
        .pkt_header_valid_o        (pkt_header_valid_o),
        .pkt_header_valid_strobe_o (pkt_header_valid_strobe_o),
        .pkt_rate_o                (pkt_rate_o),
        .pkt_len_o                 (pkt_len_o),
        .byte_o                    (byte_o),
        .byte_strobe_o             (byte_strobe_o),
        .byte_count_o              (byte_count_o),
        .fcs_out_strobe_o          (fcs_out_strobe_o),
        .fcs_ok_o                  (fcs_ok_o),
        .status_code_o             (status_code_o)
    );

endmodule

`default_nettype wire

/* tests/tb_packet_table.svh */
`ifndef TB_PACKET_TABLE_SVH
`define TB_PACKET_TABLE_SVH

// columns: name, rate, length with FCS, SIGNAL flips after parity,
// flip first FCS byte, reset after n data bytes, status, fcs_ok
task automatic fill_packet_table();
    // good packets
    add_entry("good_6m_len20", RATE_6M, 12'd20, 24'h000000, 0, 0, E_OK, 1);
    add_entry("good_54m_len37", RATE_54M, 12'd37, 24'h000000, 0, 0, E_OK, 1);

    // one FCS byte inverted
    add_entry("fcs_corrupt", RATE_24M, 12'd20, 24'h000000, 1, 0, E_WRONG_FCS, 0);

    // header rejection, bit 17 is parity so it pairs with the reserved flip
    add_entry("parity_flip", RATE_12M, 12'd12, 24'h020000, 0, 0, E_PARITY_FAIL, 0);
    add_entry("reserved_set", RATE_18M, 12'd12, 24'h020010, 0, 0, E_WRONG_RSVD, 0);
    add_entry("tail_nonzero", RATE_36M, 12'd12, 24'h040000, 0, 0, E_WRONG_TAIL, 0);
    add_entry("rate_top_clear", 4'b0101, 12'd12, 24'h000000, 0, 0, E_UNSUPPORTED_RATE, 0);

    // reset after 7 data bytes, then a clean packet
    add_entry("reset_mid_packet", RATE_48M, 12'd20, 24'h000000, 0, 7, E_OK, 0);
    add_entry("good_after_reset", RATE_9M, 12'd20, 24'h000000, 0, 0, E_OK, 1);

    // empty PSDU carries no FCS
    add_entry("zero_length", RATE_6M, 12'd0, 24'h000000, 0, 0, E_WRONG_FCS, 0);
    add_entry("good_12m_len64", RATE_12M, 12'd64, 24'h000000, 0, 0, E_OK, 1);
endtask

`endif

/* tests/tb_dot11_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_dot11_rx;

    import ofdm_signal_pkg::*;
    import rx_status_pkg::*;

    logic               clock;
    logic               equalizer_reset;
    logic               demod_start_i;
    logic [BYTE_W-1:0]  byte_i;
    logic               byte_strobe_i;
    logic               demod_is_ongoing_o;
    logic               pkt_header_valid_o;
    logic               pkt_header_valid_strobe_o;
    legacy_rate_e       pkt_rate_o;
    logic [LEN_W-1:0]   pkt_len_o;
    logic [BYTE_W-1:0]  byte_o;
    logic               byte_strobe_o;
    logic [COUNT_W-1:0] byte_count_o;
    logic               fcs_out_strobe_o;
    logic               fcs_ok_o;
    status_code_e       status_code_o;

    // table columns with one entry per packet
    string              names[$];
    logic [3:0]         rates[$];
    logic [LEN_W-1:0]   lens[$];
    logic [SIGNAL_W-1:0] sig_flips[$];
    logic               fcs_flips[$];
    int                 reset_after[$];
    status_code_e       statuses[$];
    logic               fcs_oks[$];

    // expectations shared by the driver and the monitor
    string              cur_name = "power_on_reset";
    int                 cycle = 0;
    int                 hdr_due = -1;
    int                 fcs_due = -1;
    logic               exp_hdr_good;
    status_code_e       exp_hdr_status;
    status_code_e       exp_end_status;
    logic               exp_fcs_ok;
    logic [3:0]         exp_rate;
    logic [LEN_W-1:0]   exp_len;
    logic               pkt_end_seen = 1'b0;
    logic               table_loaded = 1'b0;
    int                 error_count = 0;
    logic [7:0]         exp_data[$];
    int                 exp_count[$];
    int                 exp_cycle[$];

    dot11_rx_top uut (
        .clock                     (clock),
        .equalizer_reset           (equalizer_reset),
        .demod_start_i             (demod_start_i),
        .byte_i                    (byte_i),
        .byte_strobe_i             (byte_strobe_i),
        .demod_is_ongoing_o        (demod_is_ongoing_o),
        .pkt_header_valid_o        (pkt_header_valid_o),
        .pkt_header_valid_strobe_o (pkt_header_valid_strobe_o),
        .pkt_rate_o                (pkt_rate_o),
        .pkt_len_o                 (pkt_len_o),
        .byte_o                    (byte_o),
        .byte_strobe_o             (byte_strobe_o),
        .byte_count_o              (byte_count_o),
        .fcs_out_strobe_o          (fcs_out_strobe_o),
        .fcs_ok_o                  (fcs_ok_o),
        .status_code_o             (status_code_o)
    );

    task automatic fail_run();
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_mismatch(input string what, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("[ERROR] %s: %s expected 0x%0h, actual 0x%0h", cur_name, what, exp, act);
        error_count++;
        fail_run();
    endtask

    task automatic report_failure(input string what);
        $display("%s: %s", cur_name, what);
        error_count++;
        fail_run();
    endtask

    task automatic add_entry(input string name, input logic [3:0] rate,
                             input logic [LEN_W-1:0] len, input logic [SIGNAL_W-1:0] flips,
                             input logic fcs_flip, input int rst_after,
                             input status_code_e status, input logic fcs_ok);
        names.push_back(name);
        rates.push_back(rate);
        lens.push_back(len);
        sig_flips.push_back(flips);
        fcs_flips.push_back(fcs_flip);
        reset_after.push_back(rst_after);
        statuses.push_back(status);
        fcs_oks.push_back(fcs_ok);
    endtask

    `include "tb_packet_table.svh"

    // standard 802.11 FCS over a reflected register with the result complemented
    function automatic logic [31:0] crc32_ref(input logic [7:0] msg[$]);
        logic [31:0] crc;
        crc = 32'hFFFFFFFF;
        foreach (msg[k]) begin
            crc = crc ^ {24'h0, msg[k]};
            for (int b = 0; b < 8; b++) begin
                if (crc[0]) begin
                    crc = (crc >> 1) ^ 32'hEDB88320;
                end else begin
                    crc = crc >> 1;
                end
            end
        end
        return ~crc;
    endfunction

    //////////////////////////////
    // clock, cycle count, watchdog
    //////////////////////////////

    initial begin : clock_gen
        clock = 1'b0;
        forever begin
            #20 clock = ~clock;
        end
    end

    always @(posedge clock) begin
        cycle <= cycle + 1;
    end

    initial begin : watchdog
        int limit;
        limit = 200;
        wait (table_loaded);
        foreach (lens[i]) begin
            limit += 8 * int'(lens[i]);
        end
        repeat (limit) @(posedge clock);
        $display("watchdog expired after %0d cycles, the DUT stopped responding", limit);
        error_count++;
        fail_run();
    end

    //////////////////////////////
    // driver
    //////////////////////////////

    // tasks start and end 2 ns after a rising edge
    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clock);
            #2;
        end
    endtask

    task automatic send_byte(input logic [7:0] b);
        byte_i        = b;
        byte_strobe_i = 1'b1;
        @(posedge clock);
        #2;
        byte_strobe_i = 1'b0;
        byte_i        = '0;
    endtask

    task automatic apply_reset();
        equalizer_reset = 1'b1;
        demod_start_i   = 1'b0;
        byte_strobe_i   = 1'b0;
        hdr_due         = -1;
        fcs_due         = -1;
        idle_cycles(2);
        equalizer_reset = 1'b0;
        @(negedge clock);
        assert ({pkt_header_valid_strobe_o, byte_strobe_o, fcs_out_strobe_o} == 3'b000)
            else report_mismatch("strobes after reset", 0, {pkt_header_valid_strobe_o,
                                 byte_strobe_o, fcs_out_strobe_o});
        assert ({demod_is_ongoing_o, pkt_header_valid_o, fcs_ok_o} == 3'b000)
            else report_mismatch("levels after reset", 0, {demod_is_ongoing_o,
                                 pkt_header_valid_o, fcs_ok_o});
        assert (byte_count_o == '0) else report_mismatch("byte_count_o after reset", 0,
                                                          byte_count_o);
        assert (status_code_o == E_OK) else report_mismatch("status_code_o after reset",
                                                             E_OK, status_code_o);
        @(posedge clock);
        #2;
    endtask

    task automatic run_packet(input int idx);
        logic [SIGNAL_W-1:0] sig;
        logic [7:0]          data[$];
        logic [31:0]         fcs;
        int                  n_send;
        cur_name       = names[idx];
        exp_rate       = rates[idx];
        exp_len        = lens[idx];
        exp_end_status = statuses[idx];
        exp_fcs_ok     = fcs_oks[idx];
        exp_hdr_good   = (statuses[idx] == E_OK) || (statuses[idx] == E_WRONG_FCS);
        exp_hdr_status = exp_hdr_good ? E_OK : statuses[idx];
        pkt_end_seen   = 1'b0;

        // payload plus FCS with the low byte first
        if (lens[idx] >= 4) begin
            for (int i = 0; i < int'(lens[idx]) - 4; i++) begin
                data.push_back(8'($urandom));
            end
            fcs = crc32_ref(data);
            for (int i = 0; i < 4; i++) begin
                data.push_back(fcs[8*i +: 8]);
            end
            if (fcs_flips[idx]) begin
                data[lens[idx] - 4] = data[lens[idx] - 4] ^ 8'hFF;
            end
        end

        sig                          = '0;
        sig[RATE_LSB +: 4]           = rates[idx];
        sig[LEN_LSB +: LEN_W]        = lens[idx];
        sig[PARITY_POS]              = ^sig[PARITY_POS-1:0];
        sig                          = sig ^ sig_flips[idx];

        demod_start_i = 1'b1;
        idle_cycles(1);
        demod_start_i = 1'b0;
        for (int i = 0; i < SIGNAL_BYTES; i++) begin
            send_byte(sig[8*i +: 8]);
            if (i < SIGNAL_BYTES - 1) begin
                idle_cycles(int'($urandom % 4));
            end
        end
        hdr_due = cycle + 1;
        if (exp_hdr_good && (lens[idx] == 0)) begin
            fcs_due = cycle + 2;
        end
        // header is accepted one edge after the third byte
        idle_cycles(1 + int'($urandom % 4));

        n_send = (reset_after[idx] != 0) ? reset_after[idx] : data.size();
        for (int i = 0; i < n_send; i++) begin
            send_byte(data[i]);
            if (exp_hdr_good) begin
                exp_data.push_back(data[i]);
                exp_count.push_back(i + 1);
                exp_cycle.push_back(cycle);
                if (i == data.size() - 1) begin
                    fcs_due = cycle + 1;
                end
            end
            if (reset_after[idx] == 0) begin
                idle_cycles(int'($urandom % 4));
            end
        end

        if (reset_after[idx] != 0) begin
            // let the last forwarded byte reach the monitor first
            idle_cycles(1);
            apply_reset();
        end else begin
            wait (pkt_end_seen);
            idle_cycles(2);
        end
        assert (exp_data.size() == 0) else report_failure("forwarded data bytes went missing");
    endtask

    //////////////////////////////
    // monitor on the falling edge
    //////////////////////////////

    always @(negedge clock) begin : monitor
        logic [7:0] eb;
        int         ec;
        int         ey;
        if (!equalizer_reset) begin
            assert (pkt_header_valid_strobe_o == (cycle == hdr_due))
                else report_mismatch("pkt_header_valid_strobe_o", cycle == hdr_due,
                                     pkt_header_valid_strobe_o);
            assert (fcs_out_strobe_o == (cycle == fcs_due))
                else report_mismatch("fcs_out_strobe_o", cycle == fcs_due, fcs_out_strobe_o);

            if (pkt_header_valid_strobe_o) begin
                assert (pkt_header_valid_o == exp_hdr_good)
                    else report_mismatch("pkt_header_valid_o", exp_hdr_good, pkt_header_valid_o);
                assert (status_code_o == exp_hdr_status)
                    else report_mismatch("header status", exp_hdr_status, status_code_o);
                assert (demod_is_ongoing_o == 1'b1)
                    else report_mismatch("demod_is_ongoing_o", 1, demod_is_ongoing_o);
                if (exp_hdr_good) begin
                    assert (pkt_rate_o == exp_rate)
                        else report_mismatch("pkt_rate_o", exp_rate, pkt_rate_o);
                    assert (pkt_len_o == exp_len)
                        else report_mismatch("pkt_len_o", exp_len, pkt_len_o);
                end else begin
                    pkt_end_seen = 1'b1;
                end
            end

            if (fcs_out_strobe_o) begin
                assert (fcs_ok_o == exp_fcs_ok)
                    else report_mismatch("fcs_ok_o", exp_fcs_ok, fcs_ok_o);
                assert (status_code_o == exp_end_status)
                    else report_mismatch("FCS status", exp_end_status, status_code_o);
                pkt_end_seen = 1'b1;
            end

            if (byte_strobe_o) begin
                assert (exp_data.size() > 0)
                    else report_failure("byte strobe with no data byte pending");
                if (exp_data.size() > 0) begin
                    eb = exp_data.pop_front();
                    ec = exp_count.pop_front();
                    ey = exp_cycle.pop_front();
                    assert (byte_o == eb) else report_mismatch("byte_o", eb, byte_o);
                    assert (byte_count_o == ec)
                        else report_mismatch("byte_count_o", ec, byte_count_o);
                    assert (cycle == ey) else report_mismatch("byte strobe cycle", ey, cycle);
                end
            end
        end
    end

    initial begin : main
        equalizer_reset = 1'b1;
        demod_start_i   = 1'b0;
        byte_i          = '0;
        byte_strobe_i   = 1'b0;
        void'($urandom(32'hab03f763));
        fill_packet_table();
        table_loaded = 1'b1;
        apply_reset();
        foreach (names[t]) begin
            run_packet(t);
        end
        if (error_count == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            fail_run();
        end
    end

endmodule

`default_nettype wire

/* dot11_rx.f */
+incdir+tests
rtl/ofdm_signal_pkg.sv
rtl/rx_status_pkg.sv
rtl/signal_field_decoder.sv
rtl/fcs_crc32.sv
rtl/rx_packet_ctrl.sv
rtl/dot11_rx_top.sv
tests/tb_dot11_rx.sv

/* Makefile */
TOOL      := verilator
FLAGS     := --binary --timing --assert -Wno-fatal
TOP       := tb_dot11_rx
FILELIST  := dot11_rx.f
BUILD_DIR := obj_dir
LOG       := sim.log
FAIL_MSG  := STATUS: FAIL
PASS_MSG  := STATUS: PASS

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)

# the log decides the result, not the simulator exit code
run: compile
	-./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
